// File: list.f
design/hss_mux_pkg.sv
design/hss_mux_fifo.sv
design/hss_mux_link_ctrl.sv
design/hss_mux_frame_tx.sv
design/hss_mux_frame_rx.sv
design/hss_mux_packet_dispatcher.sv
design/hss_mux_top.sv
sim/hss_mux_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module hss_mux_tb -o hss_mux_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/hss_mux_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

# verdict comes from the log
if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// File: sim/hss_mux_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_tb import hss_mux_pkg::*;;

  localparam int   clk_half    = 20;
  localparam int   n_fixed     = 4;
  localparam int   n_rand      = 24;
  localparam int   n_steps     = n_fixed + n_rand + 3;
  localparam int   src_limit   = 400;
  localparam int   drain_limit = 2000;
  localparam int   quiet_need  = 40;
  localparam int   flood_limit = 400;
  localparam pkt_t flip_mask   = 32'h0000_0100;

  // one stimulus step
  // payload doubles as the expected packet
  typedef struct packed {
    logic                 sync;      // drain then compare counters
    logic                 rnd_link;  // random hsl_rdy
    logic                 corrupt;   // flip payload on the link
    logic [num_chans-1:0] stall;     // sinks held off
    logic [chan_bits-1:0] chan;
    pkt_t                 payload;
  } step_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  pkt_t [num_chans-1:0] pkt_data;
  logic [num_chans-1:0] pkt_vld;
  logic [num_chans-1:0] pkt_rdy;
  hsl_word_t            hsl_out;
  logic                 hsl_rdy;
  hsl_word_t            hsl_in = '0;
  logic                 hsl_vld = 1'b0;
  pkt_t [num_chans-1:0] opkt_data;
  logic [num_chans-1:0] opkt_vld;
  logic [num_chans-1:0] opkt_rdy;
  link_status_t         status;

  // scoreboard state
  pkt_t                 exp_q [num_chans][$];
  logic [num_chans-1:0] bad_src;
  logic [num_chans-1:0] in_fire;
  logic [num_chans-1:0] out_fire;
  int                   n_acc;
  int                   n_bad;
  int                   exp_gaps;
  logic                 gap_pend;

  // loopback register and corruption
  hsl_word_t            lb_word;
  logic                 lb_vld;
  logic                 arm;
  logic [chan_bits-1:0] arm_chan;
  logic                 flip_next;

  int                   val_errs;
  int                   misc_errs;
  int                   timeouts;
  logic [31:0]          seed;
  logic                 link_rnd;
  step_t                steps [n_steps];

  hss_mux_top hss_mux_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .hsl_out   (hsl_out),
    .hsl_rdy   (hsl_rdy),
    .hsl_in    (hsl_in),
    .hsl_vld   (hsl_vld),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .status    (status)
  );

  always #(clk_half) clk = ~clk;

  // --------------------
  // helpers
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic queues_empty();
    for (int c = 0; c < num_chans; c++) begin
      if (exp_q[c].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_pkt(input string name, input pkt_t got, input pkt_t exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_word(input string name, input hsl_word_t got, input hsl_word_t exp);
    if (got !== exp) begin
      $display("** Error %s: got data 0x%h kchr 0x%h, expected data 0x%h kchr 0x%h",
               name, got.data, got.kchr, exp.data, exp.kchr);
      val_errs++;
    end
  endtask

  task automatic check_status(input link_status_t got, input link_status_t exp);
    if (got.frames_sent !== exp.frames_sent) begin
      $display("** Error status.frames_sent: got 0x%h, expected 0x%h",
               got.frames_sent, exp.frames_sent);
      val_errs++;
    end
    if (got.frames_rcvd !== exp.frames_rcvd) begin
      $display("** Error status.frames_rcvd: got 0x%h, expected 0x%h",
               got.frames_rcvd, exp.frames_rcvd);
      val_errs++;
    end
    if (got.chk_errs !== exp.chk_errs) begin
      $display("** Error status.chk_errs: got 0x%h, expected 0x%h",
               got.chk_errs, exp.chk_errs);
      val_errs++;
    end
    if (got.seq_errs !== exp.seq_errs) begin
      $display("** Error status.seq_errs: got 0x%h, expected 0x%h",
               got.seq_errs, exp.seq_errs);
      val_errs++;
    end
  endtask

  // --------------------
  // loopback register and scoreboard sample on the rising edge
  always @(posedge clk) begin
    pkt_t want;
    if (!rst_n) begin
      lb_word   = '0;
      lb_vld    = 1'b0;
      arm       = 1'b0;
      flip_next = 1'b0;
      gap_pend  = 1'b0;
      in_fire   = '0;
      out_fire  = '0;
    end else begin
      // taken word reappears one cycle later
      lb_vld  = hsl_rdy;
      lb_word = hsl_out;
      if (hsl_rdy) begin
        if (flip_next) begin
          lb_word.data = hsl_out.data ^ flip_mask;
          flip_next    = 1'b0;
        end else if (arm && hsl_out.kchr == 4'b0001 && hsl_out.data[7:0] == k_sof &&
                     hsl_out.data[9:8] == arm_chan) begin
          // payload is the next word taken
          flip_next = 1'b1;
          arm       = 1'b0;
        end
      end
      for (int c = 0; c < num_chans; c++) begin
        if (pkt_vld[c] && pkt_rdy[c]) begin
          n_acc++;
          if (bad_src[c]) begin
            // dropped at the far end
            // its seq number leaves a gap
            n_bad++;
            gap_pend = 1'b1;
            arm      = 1'b1;
            arm_chan = chan_bits'(c);
          end else begin
            exp_q[c].push_back(pkt_data[c]);
            if (gap_pend) begin
              exp_gaps++;
              gap_pend = 1'b0;
            end
          end
        end
        if (opkt_vld[c] && opkt_rdy[c]) begin
          if (exp_q[c].size() == 0) begin
            $display("unexpected packet 0x%h on output channel %0d", opkt_data[c], c);
            misc_errs++;
          end else begin
            want = exp_q[c].pop_front();
            check_pkt($sformatf("opkt_data[%0d]", c), opkt_data[c], want);
          end
        end
      end
      in_fire  = pkt_vld & pkt_rdy;
      out_fire = opkt_vld & opkt_rdy;
    end
  end

  // looped word reaches the receiver with the other inputs
  always @(negedge clk) begin
    hsl_in  = lb_word;
    hsl_vld = lb_vld;
  end

  // --------------------
  // stimulus
  // all inputs change on the falling edge
  task automatic tick();
    @(negedge clk);
    // sources taken at the last rising edge go idle
    pkt_vld = pkt_vld & ~in_fire;
    if (link_rnd) begin
      seed    = lcg_next(seed);
      hsl_rdy = (seed[31:30] != 2'b00);
    end else begin
      hsl_rdy = 1'b1;
    end
  endtask

  task automatic build_table();
    // sync, rnd_link, corrupt, stall, chan, payload
    steps[0] = '{1'b0, 1'b0, 1'b0, 4'b0000, 2'd0, 32'h1357_9bdf};
    steps[1] = '{1'b0, 1'b0, 1'b0, 4'b0000, 2'd1, 32'h2468_ace0};
    steps[2] = '{1'b0, 1'b0, 1'b0, 4'b0000, 2'd2, 32'hdead_beef};
    steps[3] = '{1'b1, 1'b0, 1'b0, 4'b0000, 2'd3, 32'h0f0f_a5a5};
    // random channels and data
    for (int i = 0; i < n_rand; i++) begin
      seed = lcg_next(seed);
      steps[n_fixed + i].chan = seed[31:30];
      seed = lcg_next(seed);
      steps[n_fixed + i].payload  = seed;
      steps[n_fixed + i].sync     = (i == n_rand - 1);
      steps[n_fixed + i].rnd_link = 1'b1;
      steps[n_fixed + i].corrupt  = 1'b0;
      steps[n_fixed + i].stall    = '0;
    end
    // sink 2 stalled then a bad frame and a good one
    steps[n_fixed + n_rand]     = '{1'b1, 1'b0, 1'b0, 4'b0100, 2'd2, 32'h0000_0000};
    steps[n_fixed + n_rand + 1] = '{1'b1, 1'b0, 1'b1, 4'b0000, 2'd1, 32'hbad0_0001};
    steps[n_fixed + n_rand + 2] = '{1'b1, 1'b0, 1'b0, 4'b0000, 2'd3, 32'h600d_0003};
  endtask

  task automatic wait_src_free(input int c);
    int n;
    n = 0;
    while (pkt_vld[c]) begin
      if (n == src_limit) begin
        $display("timeout: channel %0d source was never taken", c);
        timeouts++;
        break;
      end
      tick();
      n++;
    end
  endtask

  task automatic drain_and_check();
    int           n;
    link_status_t want;
    n = 0;
    while (pkt_vld != '0 || !queues_empty() ||
           int'(status.frames_rcvd) + int'(status.chk_errs) != n_acc) begin
      if (n == drain_limit) begin
        $display("timeout: link did not drain after %0d accepted packets", n_acc);
        timeouts++;
        break;
      end
      tick();
      n++;
    end
    // counters follow from what went in
    want.frames_sent = 16'(n_acc);
    want.frames_rcvd = 16'(n_acc - n_bad);
    want.chk_errs    = 16'(n_bad);
    want.seq_errs    = 16'(exp_gaps);
    check_status(status, want);
  endtask

  task automatic flood_with_stall(input int c);
    int quiet;
    int others;
    int n;
    quiet  = 0;
    others = 0;
    n      = 0;
    while (quiet < quiet_need) begin
      if (n == flood_limit) begin
        $display("timeout: channel %0d kept taking packets with its sink stalled", c);
        timeouts++;
        break;
      end
      tick();
      n++;
      // keep every source busy
      for (int k = 0; k < num_chans; k++) begin
        if (!pkt_vld[k]) begin
          seed        = lcg_next(seed);
          pkt_data[k] = seed;
          bad_src[k]  = 1'b0;
          pkt_vld[k]  = 1'b1;
        end
      end
      if (in_fire[c]) begin
        quiet  = 0;
        others = 0;
      end else begin
        quiet++;
        for (int k = 0; k < num_chans; k++) begin
          if (k != c && out_fire[k]) begin
            others++;
          end
        end
      end
    end
    check_bit($sformatf("pkt_rdy[%0d]", c), pkt_rdy[c], 1'b0);
    if (others == 0) begin
      $display("no other channel delivered while channel %0d was blocked", c);
      misc_errs++;
    end
    // release the sink
    // pending sources still go out
    opkt_rdy = '1;
  endtask

  task automatic apply_step(input step_t s);
    int c;
    c        = int'(s.chan);
    link_rnd = s.rnd_link;
    opkt_rdy = ~s.stall;
    if (s.stall != '0) begin
      flood_with_stall(c);
    end else begin
      wait_src_free(c);
      pkt_data[c] = s.payload;
      bad_src[c]  = s.corrupt;
      pkt_vld[c]  = 1'b1;
    end
    if (s.sync) begin
      drain_and_check();
    end
  endtask

  // --------------------
  initial begin
    rst_n    = 1'b0;
    pkt_data = '0;
    pkt_vld  = '0;
    hsl_rdy  = 1'b1;
    opkt_rdy = '1;
    bad_src  = '0;
    link_rnd = 1'b0;
    seed     = 32'h0adf_1d09;
    build_table();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    tick();

    // state right after reset
    check_bit("opkt_vld any", |opkt_vld, 1'b0);
    check_bit("pkt_rdy any", |pkt_rdy, 1'b0);
    check_status(status, '0);
    check_word("hsl_out", hsl_out, '{data: {24'h0, k_idle}, kchr: 4'b0001});

    for (int i = 0; i < n_steps; i++) begin
      apply_step(steps[i]);
    end

    $display("error counts: value %0d, other %0d, timeout %0d", val_errs, misc_errs, timeouts);
    if (val_errs + misc_errs + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/hss_mux_top.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_top import hss_mux_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,

  // packet inputs
  input  pkt_t [num_chans-1:0]  pkt_data,
  input  wire [num_chans-1:0]   pkt_vld,
  output logic [num_chans-1:0]  pkt_rdy,

  // link output
  output hsl_word_t             hsl_out,
  input  wire                   hsl_rdy,

  // link input
  input  hsl_word_t             hsl_in,
  input  wire                   hsl_vld,

  // packet outputs
  output pkt_t [num_chans-1:0]  opkt_data,
  output logic [num_chans-1:0]  opkt_vld,
  input  wire [num_chans-1:0]   opkt_rdy,

  output link_status_t          status
);

  // control <-> framer
  logic                 grant_vld;
  logic [chan_bits-1:0] grant_chan;
  logic [seq_bits-1:0]  tx_seq;
  logic                 frame_start;

  // deframer -> control
  rx_event_t            rx_event;

  // deframer -> dispatcher
  logic                 dlv_vld;
  logic [chan_bits-1:0] dlv_chan;
  pkt_t                 dlv_data;

  // dispatcher -> framer
  logic [num_chans-1:0] cfc_loc;

  // --------------------
  hss_mux_link_ctrl lc (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt_vld     (pkt_vld),
    .grant_vld   (grant_vld),
    .grant_chan  (grant_chan),
    .tx_seq      (tx_seq),
    .frame_start (frame_start),
    .rx_event    (rx_event),
    .status      (status)
  );

  // transmit path
  hss_mux_frame_tx ft (
    .clk         (clk),
    .rst_n       (rst_n),
    .grant_vld   (grant_vld),
    .grant_chan  (grant_chan),
    .tx_seq      (tx_seq),
    .frame_start (frame_start),
    .pkt_data    (pkt_data),
    .pkt_rdy     (pkt_rdy),
    .cfc_loc     (cfc_loc),
    .hsl_out     (hsl_out),
    .hsl_rdy     (hsl_rdy)
  );

  // receive path
  hss_mux_frame_rx fr (
    .clk         (clk),
    .rst_n       (rst_n),
    .hsl_in      (hsl_in),
    .hsl_vld     (hsl_vld),
    .rx_event    (rx_event),
    .dlv_vld     (dlv_vld),
    .dlv_chan    (dlv_chan),
    .dlv_data    (dlv_data)
  );

  hss_mux_packet_dispatcher pd (
    .clk         (clk),
    .rst_n       (rst_n),
    .dlv_vld     (dlv_vld),
    .dlv_chan    (dlv_chan),
    .dlv_data    (dlv_data),
    .opkt_data   (opkt_data),
    .opkt_vld    (opkt_vld),
    .opkt_rdy    (opkt_rdy),
    .cfc_loc     (cfc_loc)
  );

endmodule

`default_nettype wire

// File: design/hss_mux_packet_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_packet_dispatcher import hss_mux_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,

  // deliveries from deframer
  input  wire                   dlv_vld,
  input  wire [chan_bits-1:0]   dlv_chan,
  input  pkt_t                  dlv_data,

  // packet sinks
  output pkt_t [num_chans-1:0]  opkt_data,
  output logic [num_chans-1:0]  opkt_vld,
  input  wire [num_chans-1:0]   opkt_rdy,

  // local flow-control flags
  output logic [num_chans-1:0]  cfc_loc
);

  logic [num_chans-1:0] wr_en;
  logic [fcnt_bits-1:0] free_cnt [num_chans];

  // --------------------
  // one FIFO per channel
  for (genvar i = 0; i < num_chans; i++) begin : g_chan

    // steer by channel number
    assign wr_en[i] = dlv_vld && (dlv_chan == chan_bits'(i));

    hss_mux_fifo fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en[i]),
      .wr_data  (dlv_data),
      .rd_vld   (opkt_vld[i]),
      .rd_data  (opkt_data[i]),
      .rd_rdy   (opkt_rdy[i]),
      .free_cnt (free_cnt[i])
    );

    // flag while nearly full
    // margin covers frames already on the way
    assign cfc_loc[i] = (free_cnt[i] < fcnt_bits'(cfc_margin));

  end

endmodule

`default_nettype wire

// File: design/hss_mux_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_frame_rx import hss_mux_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,

  // link input, no back-pressure
  input  hsl_word_t             hsl_in,
  input  wire                   hsl_vld,

  // reports to control block
  output rx_event_t             rx_event,

  // delivery strobe to dispatcher
  output logic                  dlv_vld,
  output logic [chan_bits-1:0]  dlv_chan,
  output pkt_t                  dlv_data
);

  typedef enum logic [1:0] {st_hunt, st_pay, st_chk} rx_state_t;

  rx_state_t           state;
  logic [frm_bits-1:0] hdr;
  pkt_t                pay;
  logic                is_ctl;
  logic                is_dat;
  logic                sof_word;
  logic                idle_word;
  logic                chk_ok;

  // --------------------
  // word decode
  assign is_ctl    = (hsl_in.kchr == kchr_ctl);
  assign is_dat    = (hsl_in.kchr == kchr_dat);
  assign sof_word  = is_ctl && (hsl_in.data[7:0] == k_sof);
  assign idle_word = is_ctl && (hsl_in.data[7:0] == k_idle);

  // recomputed check
  assign chk_ok    = (hsl_in.data == (hdr ^ pay ^ chk_const));

  // delivered frame fields stay put until next header
  assign dlv_chan  = hdr[chan_lsb +: chan_bits];
  assign dlv_data  = pay;

  // frame capture
  always_ff @(posedge clk) begin
    if (hsl_vld && (state == st_hunt) && sof_word) begin
      hdr <= hsl_in.data;
    end
    if (hsl_vld && (state == st_pay)) begin
      pay <= hsl_in.data;
    end
  end

  // --------------------
  // parser
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_hunt;
      rx_event <= '0;
      dlv_vld  <= 1'b0;
    end else begin
      // strobes last one cycle
      rx_event.frame_ok  <= 1'b0;
      rx_event.chk_err   <= 1'b0;
      rx_event.idle_seen <= 1'b0;
      dlv_vld            <= 1'b0;
      if (hsl_vld) begin
        case (state)
          st_hunt: begin
            if (sof_word) begin
              state <= st_pay;
            end else if (idle_word) begin
              rx_event.idle_seen <= 1'b1;
              rx_event.cfc       <= hsl_in.data[cfc_lsb +: num_chans];
            end
          end
          st_pay: begin
            if (is_dat) begin
              state <= st_chk;
            end else begin
              // K-char inside a frame, start over
              rx_event.chk_err <= 1'b1;
              state            <= st_hunt;
            end
          end
          default: begin
            if (is_dat && chk_ok) begin
              dlv_vld           <= 1'b1;
              rx_event.frame_ok <= 1'b1;
              rx_event.seq      <= hdr[seq_lsb +: seq_bits];
            end else begin
              // bad frame dropped here
              rx_event.chk_err <= 1'b1;
            end
            state <= st_hunt;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: design/hss_mux_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_frame_tx import hss_mux_pkg::*; (
  input  wire                        clk,
  input  wire                        rst_n,

  // grant from control block
  input  wire                        grant_vld,
  input  wire [chan_bits-1:0]        grant_chan,
  input  wire [seq_bits-1:0]         tx_seq,
  output logic                       frame_start,

  // packet sources
  input  pkt_t [num_chans-1:0]       pkt_data,
  output logic [num_chans-1:0]       pkt_rdy,

  // local flags for idle words
  input  wire [num_chans-1:0]        cfc_loc,

  // link output
  output hsl_word_t                  hsl_out,
  input  wire                        hsl_rdy
);

  // state names the word now on hsl_out
  typedef enum logic [1:0] {st_idle, st_hdr, st_pay, st_chk} tx_state_t;

  tx_state_t           state;
  logic [frm_bits-1:0] hdr;
  pkt_t                pay;
  logic                accept;

  function automatic logic [frm_bits-1:0] hdr_data(logic [chan_bits-1:0] chan,
                                                   logic [seq_bits-1:0] seq);
    logic [frm_bits-1:0] w;
    w = '0;
    w[7:0] = k_sof;
    w[chan_lsb +: chan_bits] = chan;
    w[seq_lsb +: seq_bits] = seq;
    return w;
  endfunction

  function automatic logic [frm_bits-1:0] idle_data(logic [num_chans-1:0] cfc);
    logic [frm_bits-1:0] w;
    w = '0;
    w[7:0] = k_idle;
    w[cfc_lsb +: num_chans] = cfc;
    return w;
  endfunction

  // grant taken only while an idle word leaves
  assign accept      = (state == st_idle) && hsl_rdy && grant_vld;
  assign frame_start = accept;

  always_comb begin
    pkt_rdy = '0;
    if (accept) begin
      pkt_rdy[grant_chan] = 1'b1;
    end
  end

  // frame contents, latched at grant
  always_ff @(posedge clk) begin
    if (accept) begin
      hdr <= hdr_data(grant_chan, tx_seq);
      pay <= pkt_data[grant_chan];
    end
  end

  // --------------------
  // word sequencer, next word loads as current one is taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      hsl_out <= '{data: idle_data('0), kchr: kchr_ctl};
    end else if (hsl_rdy) begin
      case (state)
        st_idle: begin
          if (grant_vld) begin
            hsl_out <= '{data: hdr_data(grant_chan, tx_seq), kchr: kchr_ctl};
            state   <= st_hdr;
          end else begin
            hsl_out <= '{data: idle_data(cfc_loc), kchr: kchr_ctl};
          end
        end
        st_hdr: begin
          hsl_out <= '{data: pay, kchr: kchr_dat};
          state   <= st_pay;
        end
        st_pay: begin
          hsl_out <= '{data: hdr ^ pay ^ chk_const, kchr: kchr_dat};
          state   <= st_chk;
        end
        default: begin
          // one idle after every frame
          hsl_out <= '{data: idle_data(cfc_loc), kchr: kchr_ctl};
          state   <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/hss_mux_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_link_ctrl import hss_mux_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,

  // packet sources asking for the link
  input  wire [num_chans-1:0]   pkt_vld,

  // grant to framer
  output logic                  grant_vld,
  output logic [chan_bits-1:0]  grant_chan,
  output logic [seq_bits-1:0]   tx_seq,
  input  wire                   frame_start,

  // reports from deframer
  input  rx_event_t             rx_event,

  output link_status_t          status
);

  logic [num_chans-1:0] cfc_rem;
  logic [num_chans-1:0] eligible;
  logic [chan_bits-1:0] last_chan;
  logic [seq_bits-1:0]  exp_seq;

  // --------------------
  // arbitration
  // --------------------

  // remote side full -> hold that channel back
  assign eligible = pkt_vld & ~cfc_rem;

  // round-robin, search starts one past last grant
  always_comb begin
    logic [chan_bits-1:0] cand;
    cand       = '0;
    grant_vld  = 1'b0;
    grant_chan = last_chan;
    for (int k = 1; k <= num_chans; k++) begin
      // index wraps, last pass lands on last_chan itself
      cand = last_chan + chan_bits'(k);
      if (!grant_vld && eligible[cand]) begin
        grant_vld  = 1'b1;
        grant_chan = cand;
      end
    end
  end

  // --------------------
  // sequence, flow state, counters
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // first search starts at channel 0
      last_chan <= chan_bits'(num_chans - 1);
      tx_seq    <= '0;
      exp_seq   <= '0;
      cfc_rem   <= '0;
      status    <= '0;
    end else begin
      if (frame_start) begin
        last_chan          <= grant_chan;
        tx_seq             <= tx_seq + 1'b1;
        status.frames_sent <= status.frames_sent + 1'b1;
      end
      // latest idle word wins
      if (rx_event.idle_seen) begin
        cfc_rem <= rx_event.cfc;
      end
      if (rx_event.chk_err) begin
        status.chk_errs <= status.chk_errs + 1'b1;
      end
      if (rx_event.frame_ok) begin
        status.frames_rcvd <= status.frames_rcvd + 1'b1;
        // gap means a dropped frame upstream
        if (rx_event.seq != exp_seq) begin
          status.seq_errs <= status.seq_errs + 1'b1;
        end
        // resync to what actually arrived
        exp_seq <= rx_event.seq + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/hss_mux_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module hss_mux_fifo import hss_mux_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,

  // write side, no back-pressure
  input  wire                   wr_en,
  input  pkt_t                  wr_data,

  // read side, first word shown
  output logic                  rd_vld,
  output pkt_t                  rd_data,
  input  wire                   rd_rdy,

  output logic [fcnt_bits-1:0]  free_cnt
);

  pkt_t                 mem [fifo_depth];
  logic [fptr_bits-1:0] wr_ptr;
  logic [fptr_bits-1:0] rd_ptr;
  logic [fcnt_bits-1:0] count;
  logic                 wr_ok;
  logic                 rd_ok;

  // full write dropped
  assign wr_ok    = wr_en && (count != fcnt_bits'(fifo_depth));
  assign rd_ok    = rd_vld && rd_rdy;

  assign rd_vld   = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign free_cnt = fcnt_bits'(fifo_depth) - count;

  // storage
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves count alone
      count <= count + fcnt_bits'(wr_ok) - fcnt_bits'(rd_ok);
    end
  end

endmodule

`default_nettype wire

// File: design/hss_mux_pkg.sv
`default_nettype none

package hss_mux_pkg;

  // --------------------
  // link and channel sizes
  localparam int num_chans  = 4;
  localparam int chan_bits  = 2;
  localparam int pkt_bits   = 32;
  localparam int frm_bits   = 32;
  localparam int kch_bits   = 4;
  localparam int seq_bits   = 8;
  localparam int cnt_bits   = 16;

  // output buffering and flow control
  localparam int fifo_depth = 4;
  localparam int fptr_bits  = $clog2(fifo_depth);
  localparam int fcnt_bits  = $clog2(fifo_depth + 1);
  localparam int cfc_margin = 2;

  // --------------------
  // K-codes, low byte of control words
  localparam logic [7:0] k_sof  = 8'hfb;
  localparam logic [7:0] k_idle = 8'hbc;

  // kchr flags, only byte 0 can be a K-character
  localparam logic [kch_bits-1:0] kchr_ctl = 4'b0001;
  localparam logic [kch_bits-1:0] kchr_dat = 4'b0000;

  // field positions in header and idle words
  localparam int chan_lsb = 8;
  localparam int seq_lsb  = 16;
  localparam int cfc_lsb  = 8;

  // folded into the check word
  localparam logic [frm_bits-1:0] chk_const = 32'h5a3c_96e1;

  // --------------------
  typedef logic [pkt_bits-1:0] pkt_t;

  typedef struct packed {
    logic [frm_bits-1:0] data;
    logic [kch_bits-1:0] kchr;
  } hsl_word_t;

  // strobes plus their side fields
  typedef struct packed {
    logic                 frame_ok;
    logic                 chk_err;
    logic                 idle_seen;
    logic [seq_bits-1:0]  seq;
    logic [num_chans-1:0] cfc;
  } rx_event_t;

  typedef struct packed {
    logic [cnt_bits-1:0] frames_sent;
    logic [cnt_bits-1:0] frames_rcvd;
    logic [cnt_bits-1:0] chk_errs;
    logic [cnt_bits-1:0] seq_errs;
  } link_status_t;

endpackage

`default_nettype wire
